/* hw/cell_classifier.sv */
module cell_classifier import cell_pkg::*, queue_pkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [ports-1:0]                      in_valid,
    input  cell_op_e [ports-1:0]                  in_op,
    input  logic [ports-1:0][dest_width-1:0]      in_dest,
    input  logic [ports-1:0][data_width-1:0]      in_data,
    input  logic [ports-1:0]                      full,
    output logic [ports-1:0]                      wr_valid,
    output logic [ports-1:0][sel_width-1:0]       wr_sel,
    output logic [ports-1:0][data_width-1:0]      wr_data,
    output logic [drop_width-1:0]                 drop_count
);
    logic [ports-1:0]                 cell_valid;
    cell_op_e [ports-1:0]             cell_op;
    logic [ports-1:0][dest_width-1:0] cell_dest;
    logic [sel_width:0]               drops; // up to ports per cycle
    logic [drop_width:0]              drop_sum;

    always_ff @(posedge clk) begin
        if (reset)
            cell_valid <= '0;
        else
            cell_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        cell_op   <= in_op;
        cell_dest <= in_dest;
        wr_data   <= in_data;
    end

    always_comb begin
        drops = '0;
        for (int p = 0; p < ports; p++) begin
            wr_sel[p]   = cell_dest[p][sel_width-1:0];
            wr_valid[p] = cell_valid[p] && cell_op[p] == op_data &&
                          cell_dest[p] < dest_width'(ports) && !full[p];
            if (cell_valid[p] && cell_op[p] != op_null && !wr_valid[p])
                drops = drops + 1'b1; // bad op, bad dest or voq full
        end
        drop_sum = {1'b0, drop_count} + (drop_width + 1)'(drops);
    end

    always_ff @(posedge clk) begin
        if (reset)
            drop_count <= '0;
        else if (drop_sum[drop_width])
            drop_count <= '1; // saturate
        else
            drop_count <= drop_sum[drop_width-1:0];
    end

endmodule

/* hw/cell_pkg.sv */
package cell_pkg;

    // payload carried by one cell
    localparam int data_width = 10;

    // width of the saturating drop counter
    localparam int drop_width = 16;

    // ingress opcode
    typedef enum logic [1:0] {
        op_null = 2'd0, // idle slot
        op_data = 2'd1, // unicast to dest
        op_drop = 2'd2  // source discards
    } cell_op_e;

endpackage

/* hw/cell_ram.sv */
module cell_ram import cell_pkg::*, queue_pkg::*; (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data,
    input  logic                  rd_en,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] rd_data
);
    logic [data_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_addr]; // holds between reads
    end

endmodule

/* hw/free_ptr_fifo.sv */
module free_ptr_fifo import queue_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd,
    input  logic                   wr,
    input  logic [addr_width-1:0]  w_data,
    output logic [addr_width-1:0]  r_data,
    output logic                   empty,
    output logic [count_width-1:0] count
);
    logic [addr_width-1:0] slots [depth];
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width-1:0] wr_ptr;

    assign r_data = slots[rd_ptr]; // head shown without a clock
    assign empty  = count == '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < depth; k++)
                slots[k] <= addr_width'(k); // every address free
        end else if (wr) begin
            slots[wr_ptr] <= w_data;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= count_width'(depth);
        end else begin
            if (rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr)
                wr_ptr <= wr_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/multi_channel_fifo.sv */
module multi_channel_fifo import queue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [addr_width-1:0] wr_data,
    input  logic                  wr_en,
    input  logic [sel_width-1:0]  wr_sel,
    input  logic                  rd_en,
    input  logic [sel_width-1:0]  rd_sel,
    output logic [addr_width-1:0] rd_data,
    output logic [ports-1:0]      empty
);
    logic [addr_width-1:0]  head [ports];
    logic [addr_width-1:0]  tail [ports];
    logic [count_width-1:0] occ [ports];
    logic [addr_width-1:0]  next_addr [depth]; // shared link table
    logic                   refill;

    assign rd_data = head[rd_sel];

    // last entry leaves while a new one arrives on the same channel
    assign refill = rd_en && rd_sel == wr_sel && occ[wr_sel] == count_width'(1);

    always_comb begin
        for (int c = 0; c < ports; c++)
            empty[c] = occ[c] == '0;
    end

    always_ff @(posedge clk) begin
        if (wr_en && occ[wr_sel] != '0)
            next_addr[tail[wr_sel]] <= wr_data; // link behind tail
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < ports; c++) begin
                head[c] <= '0;
                tail[c] <= '0;
                occ[c]  <= '0;
            end
        end else begin
            for (int c = 0; c < ports; c++)
                occ[c] <= occ[c] + count_width'(wr_en && wr_sel == sel_width'(c))
                                 - count_width'(rd_en && rd_sel == sel_width'(c));
            if (rd_en)
                head[rd_sel] <= next_addr[head[rd_sel]];
            if (wr_en) begin
                tail[wr_sel] <= wr_data;
                if (occ[wr_sel] == '0 || refill)
                    head[wr_sel] <= wr_data; // overrides the pop above
            end
        end
    end

endmodule

/* hw/queue_pkg.sv */
package queue_pkg;

    localparam int ports         = 4;
    localparam int sel_width     = 2;
    localparam int dest_width    = 3; // one bit more than sel_width
    localparam int depth         = 8; // cells per voq buffer
    localparam int addr_width    = 3;
    localparam int count_width   = 4; // holds 0 to depth
    localparam int alm_threshold = 2;

endpackage

/* hw/voq.sv */
module voq import cell_pkg::*, queue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_valid,
    input  logic [sel_width-1:0]  wr_sel,
    input  logic [data_width-1:0] wr_data,
    input  logic                  rd_valid,
    input  logic [sel_width-1:0]  rd_sel,
    output logic [data_width-1:0] rd_data,
    output logic [ports-1:0]      empty,
    output logic                  full,
    output logic                  almost_full
);
    logic [addr_width-1:0]  free_addr;  // next buffer slot to fill
    logic [addr_width-1:0]  head_addr;  // slot at head of rd_sel queue
    logic                   free_empty;
    logic [count_width-1:0] free_count;

    free_ptr_fifo free_list (
        .clk    (clk),
        .reset  (reset),
        .rd     (wr_valid),
        .wr     (rd_valid),
        .w_data (head_addr),
        .r_data (free_addr),
        .empty  (free_empty),
        .count  (free_count)
    );

    multi_channel_fifo queues (
        .clk     (clk),
        .reset   (reset),
        .wr_data (free_addr),
        .wr_en   (wr_valid),
        .wr_sel  (wr_sel),
        .rd_en   (rd_valid),
        .rd_sel  (rd_sel),
        .rd_data (head_addr),
        .empty   (empty)
    );

    cell_ram buffer (
        .clk     (clk),
        .wr_en   (wr_valid),
        .wr_addr (free_addr),
        .wr_data (wr_data),
        .rd_en   (rd_valid),
        .rd_addr (head_addr),
        .rd_data (rd_data)
    );

    assign full = free_empty;

    always_ff @(posedge clk) begin
        if (reset)
            almost_full <= 1'b0;
        else
            almost_full <= free_count <= count_width'(alm_threshold);
    end

endmodule

/* hw/voq_scheduler.sv */
module voq_scheduler import cell_pkg::*, queue_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ports-1:0][ports-1:0]      empty,   // [input][output]
    input  logic [ports-1:0][data_width-1:0] rd_data, // per input
    output logic [ports-1:0]                 rd_valid,
    output logic [ports-1:0][sel_width-1:0]  rd_sel,
    output logic [ports-1:0]                 out_valid,
    output logic [ports-1:0][sel_width-1:0]  out_src,
    output logic [ports-1:0][data_width-1:0] out_data
);
    logic [sel_width-1:0]                out_off; // output visited first
    logic [ports-1:0][sel_width-1:0]     in_ptr;  // input tried first per output
    logic [ports-1:0]                    gnt;
    logic [ports-1:0][sel_width-1:0]     gnt_src;

    always_comb begin
        logic [sel_width-1:0] o;
        logic [sel_width-1:0] i;
        rd_valid = '0;
        rd_sel   = '0;
        gnt      = '0;
        gnt_src  = '0;
        for (int k = 0; k < ports; k++) begin
            o = out_off + sel_width'(k);
            for (int j = 0; j < ports; j++) begin
                i = in_ptr[o] + sel_width'(j);
                if (!gnt[o] && !rd_valid[i] && !empty[i][o]) begin
                    gnt[o]      = 1'b1;
                    gnt_src[o]  = i;
                    rd_valid[i] = 1'b1; // input now taken
                    rd_sel[i]   = o;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_off   <= '0;
            in_ptr    <= '0;
            out_valid <= '0;
        end else begin
            out_off   <= out_off + 1'b1;
            out_valid <= gnt;
            for (int o = 0; o < ports; o++) begin
                if (gnt[o])
                    in_ptr[o] <= gnt_src[o] + 1'b1; // one past the winner
            end
        end
    end

    // grant record lines up with the ram read
    always_ff @(posedge clk) begin
        out_src <= gnt_src;
    end

    always_comb begin
        for (int o = 0; o < ports; o++)
            out_data[o] = rd_data[out_src[o]];
    end

endmodule

/* hw/voq_switch.sv */
module voq_switch import cell_pkg::*, queue_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [ports-1:0]                 in_valid,
    input  cell_op_e [ports-1:0]             in_op,
    input  logic [ports-1:0][dest_width-1:0] in_dest,
    input  logic [ports-1:0][data_width-1:0] in_data,
    output logic [ports-1:0]                 out_valid,
    output logic [ports-1:0][sel_width-1:0]  out_src,
    output logic [ports-1:0][data_width-1:0] out_data,
    output logic [drop_width-1:0]            drop_count,
    output logic [ports-1:0]                 almost_full
);
    logic [ports-1:0]                 wr_valid;
    logic [ports-1:0][sel_width-1:0]  wr_sel;
    logic [ports-1:0][data_width-1:0] wr_data;
    logic [ports-1:0]                 full;
    logic [ports-1:0][ports-1:0]      empty; // [input][output]
    logic [ports-1:0]                 rd_valid;
    logic [ports-1:0][sel_width-1:0]  rd_sel;
    logic [ports-1:0][data_width-1:0] rd_data;

    cell_classifier classifier (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_dest    (in_dest),
        .in_data    (in_data),
        .full       (full),
        .wr_valid   (wr_valid),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .drop_count (drop_count)
    );

    for (genvar g = 0; g < ports; g++) begin : g_voq
        voq voq_i (
            .clk         (clk),
            .reset       (reset),
            .wr_valid    (wr_valid[g]),
            .wr_sel      (wr_sel[g]),
            .wr_data     (wr_data[g]),
            .rd_valid    (rd_valid[g]),
            .rd_sel      (rd_sel[g]),
            .rd_data     (rd_data[g]),
            .empty       (empty[g]),
            .full        (full[g]),
            .almost_full (almost_full[g])
        );
    end

    voq_scheduler scheduler (
        .clk       (clk),
        .reset     (reset),
        .empty     (empty),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_sel    (rd_sel),
        .out_valid (out_valid),
        .out_src   (out_src),
        .out_data  (out_data)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
verilator --binary --assert -Wno-fatal --top-module voq_switch_tb \
    -f voq_switch.f -o voq_switch_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/voq_switch_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with no errors" sim.log && ! grep -q "Finished with errors" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

/* test/voq_switch_assert.sv */
module voq_switch_assert import queue_pkg::*; (
    input logic                            clk,
    input logic                            reset,
    input logic [ports-1:0]                out_valid,
    input logic [ports-1:0][sel_width-1:0] out_src,
    input logic [ports-1:0]                rd_valid,
    input logic [ports-1:0][sel_width-1:0] rd_sel,
    input logic [ports-1:0][ports-1:0]     empty,
    input logic [ports-1:0]                almost_full
);
    logic src_clash; // one source seen on two outputs

    always_comb begin
        src_clash = 1'b0;
        for (int a = 0; a < ports; a++) begin
            for (int b = a + 1; b < ports; b++) begin
                if (out_valid[a] && out_valid[b] && out_src[a] == out_src[b])
                    src_clash = 1'b1;
            end
        end
    end

    one_src_per_cycle: assert property (@(posedge clk) disable iff (reset) !src_clash)
        else $error("two outputs delivered cells from the same input in one cycle");

    for (genvar i = 0; i < ports; i++) begin : g_rd
        rd_nonempty: assert property (@(posedge clk) disable iff (reset)
            rd_valid[i] |-> !empty[i][rd_sel[i]])
            else $error("input %0d was granted a read from an empty queue", i);
    end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> almost_full == '0 && out_valid == '0)
        else $error("almost_full or out_valid high in the cycle after reset");

endmodule

bind voq_switch voq_switch_assert voq_switch_assert_i (.*);

/* test/voq_switch_tb.sv */
module voq_switch_tb import cell_pkg::*, queue_pkg::*; ();
    localparam int period          = 4;
    localparam int reset_cycles    = 10;
    localparam int drain_allowance = 60; // per test

    logic                             clk;
    logic                             reset;
    logic [ports-1:0]                 in_valid;
    cell_op_e [ports-1:0]             in_op;
    logic [ports-1:0][dest_width-1:0] in_dest;
    logic [ports-1:0][data_width-1:0] in_data;
    logic [ports-1:0]                 out_valid;
    logic [ports-1:0][sel_width-1:0]  out_src;
    logic [ports-1:0][data_width-1:0] out_data;
    logic [drop_width-1:0]            drop_count;
    logic [ports-1:0]                 almost_full;

    logic [data_width-1:0] exp_q [ports][ports][$]; // [src][dst]
    string            lines [$];
    string            test_name;
    int               errors;
    int               test_errors;
    int               tests;
    int               failed_tests;
    int               lost;        // expected cells skipped at egress
    int               model_drops; // drops the classifier rule predicts
    int               exp_drops;
    int               drop_base;
    int               run_cycles;
    logic             strict;      // no blocking drops expected
    logic [ports-1:0] alm_exp;
    logic [ports-1:0] alm_seen;

    voq_switch voq_switch_i (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic drive_idle();
        for (int p = 0; p < ports; p++) begin
            in_valid[p] = 1'b0;
            in_op[p]    = op_null;
            in_dest[p]  = '0;
            in_data[p]  = '0;
        end
    endtask

    task automatic drive_cycles(input string line);
        int cycles;
        int v [ports];
        int op [ports];
        int dest [ports];
        int data [ports];
        void'($sscanf(line, "%d %d %d %d %h %d %d %d %h %d %d %d %h %d %d %d %h", cycles,
            v[0], op[0], dest[0], data[0], v[1], op[1], dest[1], data[1],
            v[2], op[2], dest[2], data[2], v[3], op[3], dest[3], data[3]));
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            #1;
            for (int p = 0; p < ports; p++) begin
                in_valid[p] = v[p] != 0;
                in_op[p]    = cell_op_e'(op[p]);
                in_dest[p]  = dest_width'(dest[p]);
                in_data[p]  = data_width'(data[p] + c);
                if (v[p] != 0 && op[p] == int'(op_data) && dest[p] < ports)
                    exp_q[p][dest[p]].push_back(in_data[p]);
                else if (v[p] != 0 && op[p] != int'(op_null))
                    model_drops++;
            end
        end
    endtask

    // egress monitor sampled mid-cycle
    always @(negedge clk) begin
        logic [data_width-1:0] exp;
        logic                  found;
        if (!reset && test_name != "") begin
            alm_seen = alm_seen | almost_full;
            for (int o = 0; o < ports; o++) begin
                if (out_valid[o]) begin
                    found = 1'b0;
                    if (strict && exp_q[out_src[o]][o].size() > 0) begin
                        exp = exp_q[out_src[o]][o].pop_front();
                        check_value($sformatf("out_data[%0d]", o), exp, out_data[o]);
                        found = 1'b1;
                    end
                    while (!strict && !found && exp_q[out_src[o]][o].size() > 0) begin
                        exp = exp_q[out_src[o]][o].pop_front();
                        if (exp == out_data[o])
                            found = 1'b1;
                        else
                            lost++; // dropped at a full voq
                    end
                    if (!found) begin
                        $display("%s: output %0d delivered cell %h from input %0d, never expected",
                            test_name, o, out_data[o], out_src[o]);
                        errors++;
                        test_errors++;
                    end
                end
            end
        end
    end

    task automatic report_test();
        tests++;
        if (test_errors != 0)
            failed_tests++;
        $display("test %s: %s (%0d errors)", test_name,
            test_errors == 0 ? "passed" : "failed", test_errors);
    endtask

    task automatic start_test(input string line);
        string drops_s;
        void'($sscanf(line, "test %s %s %h", test_name, drops_s, alm_exp));
        strict      = drops_s != "-";
        exp_drops   = strict ? drops_s.atoi() : -1;
        drop_base   = int'(drop_count);
        test_errors = 0;
        lost        = 0;
        model_drops = 0;
        alm_seen    = '0;
    endtask

    task automatic finish_test();
        int leftover;
        int growth;
        @(posedge clk);
        #1;
        drive_idle();
        do
            @(negedge clk);
        while (!(&voq_switch_i.empty) || voq_switch_i.wr_valid != '0 || out_valid != '0);
        leftover = 0;
        for (int s = 0; s < ports; s++) begin
            for (int d = 0; d < ports; d++) begin
                leftover += exp_q[s][d].size();
                exp_q[s][d].delete();
            end
        end
        growth = int'(drop_count) - drop_base;
        if (strict)
            check_value("drop_count growth", exp_drops, growth);
        check_value("cells not delivered", growth - model_drops, lost + leftover);
        check_value("almost_full raised", alm_exp, alm_seen);
        check_value("almost_full after drain", 0, almost_full);
        report_test();
    endtask

    initial begin
        int    fd;
        int    cycles;
        string line;
        reset = 1'b1;
        drive_idle();
        run_cycles = reset_cycles + drain_allowance;
        fd = $fopen("test/voq_switch_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open test/voq_switch_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                    if (line.getc(0) == "t")
                        run_cycles += drain_allowance;
                    else if ($sscanf(line, "%d", cycles) == 1)
                        run_cycles += cycles;
                end
            end
            $fclose(fd);
        end
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        test_name   = "reset_state";
        test_errors = 0;
        check_value("out_valid", 0, out_valid);
        check_value("almost_full", 0, almost_full);
        check_value("drop_count", 0, drop_count);
        report_test();
        test_name = "";
        foreach (lines[n]) begin
            if (lines[n].getc(0) == "t") begin
                if (test_name != "")
                    finish_test();
                start_test(lines[n]);
            end else begin
                drive_cycles(lines[n]);
            end
        end
        if (test_name != "")
            finish_test();
        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        #1;
        #(run_cycles * period);
        $display("timeout: the switch did not drain within %0d cycles", run_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* test/voq_switch_trace.txt */
# test <name> <expected drop_count growth, or - when blocking drops are allowed> <almost_full mask, hex>
# <cycles> then per port 0..3: <valid> <op 0 null 1 data 2 drop> <dest> <data hex, +1 each cycle>
test single_path 0 0
6 1 1 2 010 0 0 0 000 0 0 0 000 0 0 0 000
test full_mesh 0 0
2 1 1 0 100 1 1 1 140 1 1 2 180 1 1 3 1c0
2 1 1 1 110 1 1 2 150 1 1 3 190 1 1 0 1d0
2 1 1 2 120 1 1 3 160 1 1 0 1a0 1 1 1 1e0
2 1 1 3 130 1 1 0 170 1 1 1 1b0 1 1 2 1f0
test op_and_range 6 0
2 1 0 1 200 1 2 1 210 1 1 4 220 0 1 1 230
1 1 1 3 240 1 1 7 250 1 2 0 260 1 1 3 270
test contention - f
16 1 1 0 300 1 1 0 340 1 1 0 380 1 1 0 3c0

/* voq_switch.f */
hw/cell_pkg.sv
hw/queue_pkg.sv
hw/cell_classifier.sv
hw/free_ptr_fifo.sv
hw/multi_channel_fifo.sv
hw/cell_ram.sv
hw/voq.sv
hw/voq_scheduler.sv
hw/voq_switch.sv
test/voq_switch_assert.sv
test/voq_switch_tb.sv
